//--- dv/dual_issue_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module dual_issue_assertions (
  input logic                             clk,
  input logic                             arst_n,
  input logic                             stall,
  input logic                             hold,
  input logic [isa_pkg::inst_width-1:0]   instr0_in,
  input logic [isa_pkg::inst_width-1:0]   instr1_in,
  input logic [issue_pkg::addr_width-1:0] pc0_in,
  input logic [issue_pkg::addr_width-1:0] pc1_in,
  input logic [isa_pkg::inst_width-1:0]   instr0_out,
  input logic [isa_pkg::inst_width-1:0]   instr1_out,
  input logic [issue_pkg::addr_width-1:0] pc0_out,
  input logic [issue_pkg::addr_width-1:0] pc1_out,
  input logic                             first_out
);

  int unsigned fail_count = 0; // read by the testbench.

  logic half_due; // second half of a split pair is next.
  logic [issue_pkg::pipe_bits-1:0] cls0;
  logic [issue_pkg::pipe_bits-1:0] cls1;
  logic same_pipe;
  logic swap_now;
  logic one_slot;
  logic [isa_pkg::inst_width-1:0] exp_instr0;
  logic [isa_pkg::inst_width-1:0] exp_instr1;
  logic [issue_pkg::addr_width-1:0] exp_pc0;
  logic [issue_pkg::addr_width-1:0] exp_pc1;

  function automatic logic [issue_pkg::pipe_bits-1:0] class_of(
    input logic [isa_pkg::inst_width-1:0] instr
  );
    logic [isa_pkg::opcode_bits-1:0] op;
    op = instr[isa_pkg::opcode_msb:isa_pkg::opcode_lsb];
    if (op[isa_pkg::opcode_bits-1]) begin
      return op[isa_pkg::opcode_bits-2] ? issue_pkg::pipe_branch : issue_pkg::pipe_memory;
    end
    if (op == isa_pkg::op_cmp || op == isa_pkg::op_test ||
        op == isa_pkg::op_cmpi || op == isa_pkg::op_testi) begin
      return issue_pkg::pipe_branch;
    end
    return issue_pkg::pipe_dont_care;
  endfunction

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      half_due <= 1'b0;
    end else if (!stall) begin
      half_due <= hold;
    end
  end

  always_comb begin
    cls0 = class_of(instr0_in);
    cls1 = class_of(instr1_in);
    same_pipe = (cls0 == cls1) && (cls0 != issue_pkg::pipe_dont_care);
    swap_now = (cls0 == issue_pkg::pipe_memory && cls1 != issue_pkg::pipe_memory) ||
               (cls0 == issue_pkg::pipe_dont_care && cls1 == issue_pkg::pipe_branch);
    exp_instr0 = swap_now ? instr1_in : instr0_in;
    exp_instr1 = swap_now ? instr0_in : instr1_in;
    exp_pc0 = swap_now ? pc1_in : pc0_in;
    exp_pc1 = swap_now ? pc0_in : pc1_in;
    one_slot = (instr0_out == isa_pkg::nop_instruction) !=
               (instr1_out == isa_pkg::nop_instruction);
  end

  reset_state: assert property (@(posedge clk)
    (!arst_n || $rose(arst_n)) |->
      (instr0_out == isa_pkg::nop_instruction && instr1_out == isa_pkg::nop_instruction &&
       pc0_out == '0 && pc1_out == '0 && !first_out))
  else begin
    fail_count++;
    $error("outputs not in reset state");
  end

  slot0_legal: assert property (@(posedge clk) disable iff (!arst_n)
    class_of(instr0_out) != issue_pkg::pipe_memory)
  else begin
    fail_count++;
    $error("memory instruction in slot 0");
  end

  slot1_legal: assert property (@(posedge clk) disable iff (!arst_n)
    class_of(instr1_out) != issue_pkg::pipe_branch || instr1_out == isa_pkg::nop_instruction)
  else begin
    fail_count++;
    $error("branch instruction in slot 1");
  end

  split_hold: assert property (@(posedge clk) disable iff (!arst_n)
    (!half_due && same_pipe) |-> hold)
  else begin
    fail_count++;
    $error("hold low for a fresh same-pipe pair");
  end

  second_half_hold: assert property (@(posedge clk) disable iff (!arst_n)
    half_due |-> !hold)
  else begin
    fail_count++;
    $error("hold high for the second half of a split");
  end

  // the only instruction sits in slot 1 exactly when first is high.
  first_half_out: assert property (@(posedge clk) disable iff (!arst_n)
    ($past(arst_n) && $past(hold && !stall)) |->
      (one_slot && first_out == (instr1_out != isa_pkg::nop_instruction)))
  else begin
    fail_count++;
    $error("first half of a split has the wrong slots");
  end

  // second half issued one edge after the first half.
  second_half_out: assert property (@(posedge clk) disable iff (!arst_n)
    ($past(arst_n, 2) && $past(hold && !stall, 2) && $past(!stall)) |->
      (one_slot && first_out == (instr1_out != isa_pkg::nop_instruction) &&
       (instr0_out == $past(instr1_in) || instr1_out == $past(instr1_in))))
  else begin
    fail_count++;
    $error("second half of a split is wrong");
  end

  stall_freeze: assert property (@(posedge clk) disable iff (!arst_n)
    ($past(arst_n) && $past(stall)) |->
      (instr0_out == $past(instr0_out) && instr1_out == $past(instr1_out) &&
       pc0_out == $past(pc0_out) && pc1_out == $past(pc1_out) &&
       first_out == $past(first_out)))
  else begin
    fail_count++;
    $error("outputs changed under stall");
  end

  pair_latency: assert property (@(posedge clk) disable iff (!arst_n)
    ($past(arst_n) && $past(!stall && !hold && !half_due)) |->
      (instr0_out == $past(exp_instr0) && instr1_out == $past(exp_instr1) &&
       pc0_out == $past(exp_pc0) && pc1_out == $past(exp_pc1) &&
       first_out == $past(swap_now)))
  else begin
    fail_count++;
    $error("unsplit pair not routed after one edge");
  end

endmodule

bind dual_issue_top dual_issue_assertions assertions_i (
  .clk        (clk),
  .arst_n     (arst_n),
  .stall      (stall),
  .hold       (hold),
  .instr0_in  (instr0_in),
  .instr1_in  (instr1_in),
  .pc0_in     (pc0_in),
  .pc1_in     (pc1_in),
  .instr0_out (instr0_out),
  .instr1_out (instr1_out),
  .pc0_out    (pc0_out),
  .pc1_out    (pc1_out),
  .first_out  (first_out)
);

`default_nettype wire

//--- dv/dual_issue_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dual_issue_tb;

  localparam int prog_len = 400;
  localparam int pair_count = prog_len / 2;
  localparam int cycle_limit = 8 * prog_len + 100;
  localparam logic [issue_pkg::addr_width-1:0] pc_base = 16'h0100;

  // directed class pairs, {slot 0, slot 1}.
  localparam logic [3:0] directed [11] = '{
    {issue_pkg::pipe_branch, issue_pkg::pipe_branch},
    {issue_pkg::pipe_memory, issue_pkg::pipe_memory},
    {issue_pkg::pipe_memory, issue_pkg::pipe_branch},
    {issue_pkg::pipe_memory, issue_pkg::pipe_dont_care},
    {issue_pkg::pipe_dont_care, issue_pkg::pipe_branch},
    {issue_pkg::pipe_branch, issue_pkg::pipe_memory},
    {issue_pkg::pipe_branch, issue_pkg::pipe_dont_care},
    {issue_pkg::pipe_dont_care, issue_pkg::pipe_memory},
    {issue_pkg::pipe_dont_care, issue_pkg::pipe_dont_care},
    {issue_pkg::pipe_branch, issue_pkg::pipe_branch}, // back to back splits.
    {issue_pkg::pipe_memory, issue_pkg::pipe_memory}
  };

  logic clk;
  logic arst_n;
  logic stall;
  logic hold;
  logic [isa_pkg::inst_width-1:0] instr0_in;
  logic [isa_pkg::inst_width-1:0] instr1_in;
  logic [issue_pkg::addr_width-1:0] pc0_in;
  logic [issue_pkg::addr_width-1:0] pc1_in;
  logic [isa_pkg::inst_width-1:0] instr0_out;
  logic [isa_pkg::inst_width-1:0] instr1_out;
  logic [issue_pkg::addr_width-1:0] pc0_out;
  logic [issue_pkg::addr_width-1:0] pc1_out;
  logic first_out;

  logic [isa_pkg::inst_width-1:0] prog [prog_len];
  logic edge_stall;
  logic edge_hold;
  int pair_idx;
  int issued;
  int cycles;

  tb_clock clock_i (
    .clk    (clk),
    .arst_n (arst_n)
  );

  dual_issue_top dual_issue_top_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .stall      (stall),
    .instr0_in  (instr0_in),
    .instr1_in  (instr1_in),
    .pc0_in     (pc0_in),
    .pc1_in     (pc1_in),
    .hold       (hold),
    .instr0_out (instr0_out),
    .instr1_out (instr1_out),
    .pc0_out    (pc0_out),
    .pc1_out    (pc1_out),
    .first_out  (first_out)
  );

  // what the DUT saw at the last rising edge.
  always @(posedge clk) begin
    edge_stall <= stall;
    edge_hold <= hold;
  end

  function automatic logic [issue_pkg::addr_width-1:0] pc_of(input int k);
    return pc_base + issue_pkg::addr_width'(4 * k);
  endfunction

  function automatic logic [isa_pkg::opcode_bits-1:0] opcode_for(
    input logic [issue_pkg::pipe_bits-1:0] cls
  );
    logic [isa_pkg::opcode_bits-1:0] op;
    int pick;
    pick = int'($urandom % 6);
    case (cls)
      issue_pkg::pipe_branch: begin
        case (pick)
          0: op = isa_pkg::op_cmp;
          1: op = isa_pkg::op_test;
          2: op = isa_pkg::op_cmpi;
          3: op = isa_pkg::op_testi;
          default: op = {2'b11, 4'($urandom)}; // jumps.
        endcase
      end
      issue_pkg::pipe_memory: begin
        op = {2'b10, 4'($urandom)};
      end
      default: begin
        op = {1'b0, 5'($urandom)};
        if (op == isa_pkg::op_cmp || op == isa_pkg::op_test ||
            op == isa_pkg::op_cmpi || op == isa_pkg::op_testi) begin
          op = '0; // opcode zero is still any slot.
        end
      end
    endcase
    return op;
  endfunction

  task automatic build_program();
    for (int k = 0; k < prog_len; k++) begin
      logic [issue_pkg::pipe_bits-1:0] cls;
      if (k < 2 * $size(directed)) begin
        cls = (k % 2 == 0) ? directed[k/2][3:2] : directed[k/2][1:0];
      end else begin
        case ($urandom % 3)
          0: cls = issue_pkg::pipe_dont_care;
          1: cls = issue_pkg::pipe_branch;
          default: cls = issue_pkg::pipe_memory;
        endcase
      end
      // nonzero low bits keep every word distinct from the no-op.
      prog[k] = {opcode_for(cls), 10'h2a5, pc_of(k)};
    end
  endtask

  task automatic present_pair();
    if (pair_idx < pair_count) begin
      instr0_in = prog[2*pair_idx];
      instr1_in = prog[2*pair_idx+1];
      pc0_in = pc_of(2 * pair_idx);
      pc1_in = pc_of(2 * pair_idx + 1);
    end else begin
      instr0_in = isa_pkg::nop_instruction; // program drained.
      instr1_in = isa_pkg::nop_instruction;
      pc0_in = '0;
      pc1_in = '0;
    end
  endtask

  task automatic abort_run(input string msg);
    $display("error at time %0t: %s", $time, msg);
    $display("test failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_slot(
    input logic [isa_pkg::inst_width-1:0] instr,
    input logic [issue_pkg::addr_width-1:0] pc
  );
    if (instr != isa_pkg::nop_instruction) begin
      if (issued >= prog_len) begin
        abort_run($sformatf("extra instruction %h issued at pc %h", instr, pc));
      end else if (pc != pc_of(issued) || instr != prog[issued]) begin
        abort_run($sformatf("issued pc %h instr %h, expected pc %h instr %h",
                            pc, instr, pc_of(issued), prog[issued]));
      end
      issued++;
    end
  endtask

  initial begin
    void'($urandom(32'h594e57c9));
    stall = 1'b0;
    pair_idx = 0;
    issued = 0;
    cycles = 0;
    build_program();
    present_pair();
    wait (arst_n === 1'b1);

    while (issued < prog_len) begin
      @(negedge clk);
      cycles++;
      if (cycles > cycle_limit) begin
        abort_run($sformatf("timeout, only %0d of %0d instructions issued in %0d cycles",
                            issued, prog_len, cycles));
      end
      if (dual_issue_top_i.assertions_i.fail_count != 0) begin
        abort_run("a concurrent assertion on the DUT failed");
      end
      if (!edge_stall) begin
        // older instruction first.
        if (first_out) begin
          check_slot(instr1_out, pc1_out);
          check_slot(instr0_out, pc0_out);
        end else begin
          check_slot(instr0_out, pc0_out);
          check_slot(instr1_out, pc1_out);
        end
        if (!edge_hold) begin
          pair_idx++;
        end
      end
      stall = ($urandom % 5) == 0;
      present_pair();
    end

    @(negedge clk);
    if (dual_issue_top_i.assertions_i.fail_count != 0) begin
      abort_run("a concurrent assertion on the DUT failed at the end");
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic arst_n
);

  localparam int half_period = 10; // 20 ns clock.
  localparam int reset_cycles = 3;

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1; // released between edges.
  end

endmodule

`default_nettype wire

//--- flist.f
src/isa_pkg.sv
src/issue_pkg.sv
src/pair_if.sv
src/pipe_classify.sv
src/steer.sv
src/issue_latch.sv
src/dual_issue_top.sv
dv/tb_clock.sv
dv/dual_issue_assertions.sv
dv/dual_issue_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build with verilator, run, and look for the pass line in the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

# the error limit lets the testbench see an assertion error and report it.
verilator --binary --timing --assert --top-module dual_issue_tb -f flist.f -o dual_issue_sim \
  && { ./obj_dir/dual_issue_sim +verilator+error+limit+1000 > sim.log 2>&1 || true; } \
  && cat sim.log \
  && grep -qx "test passed" sim.log \
  && echo "simulation ok" \
  || { echo "simulation failed, see sim.log"; exit 1; }

//--- src/dual_issue_top.sv
`timescale 1ns/1ps
`default_nettype none

module dual_issue_top (
  input  logic                             clk,
  input  logic                             arst_n,
  input  logic                             stall,
  input  logic [isa_pkg::inst_width-1:0]   instr0_in,
  input  logic [isa_pkg::inst_width-1:0]   instr1_in,
  input  logic [issue_pkg::addr_width-1:0] pc0_in,
  input  logic [issue_pkg::addr_width-1:0] pc1_in,
  output logic                             hold,
  output logic [isa_pkg::inst_width-1:0]   instr0_out,
  output logic [isa_pkg::inst_width-1:0]   instr1_out,
  output logic [issue_pkg::addr_width-1:0] pc0_out,
  output logic [issue_pkg::addr_width-1:0] pc1_out,
  output logic                             first_out
);

  logic [issue_pkg::pipe_bits-1:0] class0;
  logic [issue_pkg::pipe_bits-1:0] class1;
  logic first;

  pair_if pair_in ();
  pair_if pair_steered ();

  // fetch pair.
  assign pair_in.instr0 = instr0_in;
  assign pair_in.instr1 = instr1_in;
  assign pair_in.pc0 = pc0_in;
  assign pair_in.pc1 = pc1_in;

  pipe_classify classify0_i (
    .opcode     (instr0_in[isa_pkg::opcode_msb:isa_pkg::opcode_lsb]),
    .pipe_class (class0)
  );

  pipe_classify classify1_i (
    .opcode     (instr1_in[isa_pkg::opcode_msb:isa_pkg::opcode_lsb]),
    .pipe_class (class1)
  );

  steer steer_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .stall    (stall),
    .pair_in  (pair_in),
    .class0   (class0),
    .class1   (class1),
    .pair_out (pair_steered),
    .split    (hold), // fetch re-presents the pair.
    .first    (first)
  );

  issue_latch issue_latch_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .stall      (stall),
    .pair_in    (pair_steered),
    .first      (first),
    .instr0_out (instr0_out),
    .instr1_out (instr1_out),
    .pc0_out    (pc0_out),
    .pc1_out    (pc1_out),
    .first_out  (first_out)
  );

endmodule

`default_nettype wire

//--- src/isa_pkg.sv
`default_nettype none

package isa_pkg;

  // instruction word.
  localparam int inst_width = 32;

  // opcode sits in the top six bits.
  localparam int opcode_msb = 31;
  localparam int opcode_lsb = 26;
  localparam int opcode_bits = opcode_msb - opcode_lsb + 1;

  // register form, top bits 00.
  // the rest of this group (add, sub, and, or ...) may go to either pipe.
  localparam logic [opcode_bits-1:0] op_cmp = 6'b001010;
  localparam logic [opcode_bits-1:0] op_test = 6'b001011;

  // immediate form, top bits 01.
  localparam logic [opcode_bits-1:0] op_cmpi = 6'b011010;
  localparam logic [opcode_bits-1:0] op_testi = 6'b011011;

  // top bits 10 are loads and stores, 11 are jumps.
  // neither needs a named value here.

  // all-zero word, opcode zero.
  localparam logic [inst_width-1:0] nop_instruction = '0;

endpackage

`default_nettype wire

//--- src/issue_latch.sv
`timescale 1ns/1ps
`default_nettype none

module issue_latch (
  input  logic                             clk,
  input  logic                             arst_n,
  input  logic                             stall,
  pair_if.dst                              pair_in,
  input  logic                             first,
  output logic [isa_pkg::inst_width-1:0]   instr0_out,
  output logic [isa_pkg::inst_width-1:0]   instr1_out,
  output logic [issue_pkg::addr_width-1:0] pc0_out,
  output logic [issue_pkg::addr_width-1:0] pc1_out,
  output logic                             first_out
);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      instr0_out <= isa_pkg::nop_instruction;
      instr1_out <= isa_pkg::nop_instruction;
      pc0_out <= '0;
      pc1_out <= '0;
      first_out <= 1'b0;
    end else if (!stall) begin
      // frozen while downstream is stalled.
      instr0_out <= pair_in.instr0;
      instr1_out <= pair_in.instr1;
      pc0_out <= pair_in.pc0;
      pc1_out <= pair_in.pc1;
      first_out <= first;
    end
  end

endmodule

`default_nettype wire

//--- src/issue_pkg.sv
`default_nettype none

package issue_pkg;

  // program counter.
  localparam int addr_width = 16;

  localparam int pipe_bits = 2;

  // which slot an instruction needs.
  localparam logic [pipe_bits-1:0] pipe_dont_care = 2'd0; // alu op, any slot.
  localparam logic [pipe_bits-1:0] pipe_branch = 2'd1;    // slot 0 only.
  localparam logic [pipe_bits-1:0] pipe_memory = 2'd2;    // slot 1 only.

endpackage

`default_nettype wire

//--- src/pair_if.sv
`timescale 1ns/1ps
`default_nettype none

// one instruction pair with its program counters.
interface pair_if;

  logic [isa_pkg::inst_width-1:0] instr0;
  logic [isa_pkg::inst_width-1:0] instr1;
  logic [issue_pkg::addr_width-1:0] pc0;
  logic [issue_pkg::addr_width-1:0] pc1;

  modport src (
    output instr0,
    output instr1,
    output pc0,
    output pc1
  );

  modport dst (
    input instr0,
    input instr1,
    input pc0,
    input pc1
  );

endinterface

`default_nettype wire

//--- src/pipe_classify.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_classify (
  input  logic [isa_pkg::opcode_bits-1:0] opcode,
  output logic [issue_pkg::pipe_bits-1:0] pipe_class
);

  logic [1:0] group;

  assign group = opcode[isa_pkg::opcode_bits-1 -: 2];

  always_comb begin
    pipe_class = issue_pkg::pipe_dont_care;
    if (opcode != '0) begin
      case (group)
        2'b00: begin // register alu ops.
          if (opcode == isa_pkg::op_cmp || opcode == isa_pkg::op_test) begin
            pipe_class = issue_pkg::pipe_branch;
          end
        end
        2'b01: begin // immediate alu ops.
          if (opcode == isa_pkg::op_cmpi || opcode == isa_pkg::op_testi) begin
            pipe_class = issue_pkg::pipe_branch;
          end
        end
        2'b10: begin
          pipe_class = issue_pkg::pipe_memory; // loads, stores.
        end
        default: begin
          pipe_class = issue_pkg::pipe_branch; // jumps.
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/steer.sv
`timescale 1ns/1ps
`default_nettype none

module steer (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            stall,
  pair_if.dst                             pair_in,
  input  logic [issue_pkg::pipe_bits-1:0] class0,
  input  logic [issue_pkg::pipe_bits-1:0] class1,
  pair_if.src                             pair_out,
  output logic                            split,
  output logic                            first
);

  // high while the second half of a split pair is due.
  logic prev_split;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      prev_split <= 1'b0;
    end else if (!stall) begin
      prev_split <= split;
    end
  end

  always_comb begin
    // straight through unless a rule below says otherwise.
    pair_out.instr0 = pair_in.instr0;
    pair_out.instr1 = pair_in.instr1;
    pair_out.pc0 = pair_in.pc0;
    pair_out.pc1 = pair_in.pc1;
    split = 1'b0;
    first = 1'b0;

    case ({class0, class1})
      {issue_pkg::pipe_branch, issue_pkg::pipe_branch}: begin
        // both want slot 0, one per cycle.
        pair_out.instr1 = isa_pkg::nop_instruction;
        pair_out.pc1 = '0;
        if (!prev_split) begin
          split = 1'b1;
        end else begin
          pair_out.instr0 = pair_in.instr1;
          pair_out.pc0 = pair_in.pc1;
        end
      end
      {issue_pkg::pipe_memory, issue_pkg::pipe_memory}: begin
        // both want slot 1.
        pair_out.instr0 = isa_pkg::nop_instruction;
        pair_out.pc0 = '0;
        first = 1'b1;
        if (!prev_split) begin
          pair_out.instr1 = pair_in.instr0;
          pair_out.pc1 = pair_in.pc0;
          split = 1'b1;
        end
      end
      {issue_pkg::pipe_memory, issue_pkg::pipe_branch},
      {issue_pkg::pipe_memory, issue_pkg::pipe_dont_care},
      {issue_pkg::pipe_dont_care, issue_pkg::pipe_branch}: begin
        // each fits only the other slot, so swap.
        pair_out.instr0 = pair_in.instr1;
        pair_out.instr1 = pair_in.instr0;
        pair_out.pc0 = pair_in.pc1;
        pair_out.pc1 = pair_in.pc0;
        first = 1'b1; // older one now in slot 1.
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire
